//--- logic/idctl_settings.svh
`ifndef IDCTL_SETTINGS_SVH
`define IDCTL_SETTINGS_SVH

////////////////////////////////////////////////////////////
// widths
////////////////////////////////////////////////////////////

// host word and word index
`define IDCTL_DATA_W 32
`define IDCTL_ADDR_W 4
// control bits clocked into each aux CPLD
`define IDCTL_CBITS 8
// bits per JTAG shift word, same for TDI, TMS and TDO
`define IDCTL_JBITS 8

////////////////////////////////////////////////////////////
// identification and key words
////////////////////////////////////////////////////////////

// ascii 'RDNT'
`define IDCTL_DEVICE_ID 32'h5244_4e54
// firmware version word
`define IDCTL_VERSION 32'h0103_0002
// ascii 'FKey', arms the reboot capture
`define IDCTL_KEY 32'h464b_6579

// register map, word indices
`define IDCTL_REG_ID 4'd0
`define IDCTL_REG_VERSION 4'd1
`define IDCTL_REG_CPLD 4'd2
`define IDCTL_REG_MODE 4'd3
`define IDCTL_REG_LED 4'd4
`define IDCTL_REG_JTAG0 4'd5
`define IDCTL_REG_JTAG1 4'd6

`endif

//--- logic/idctl_pkg.sv
`default_nettype none

`include "idctl_settings.svh"

package idctl_pkg;

        // one host word
        typedef logic [`IDCTL_DATA_W-1:0] word_t;

        // word index on the host port
        typedef logic [`IDCTL_ADDR_W-1:0] reg_addr_t;

        // control bits for one aux CPLD
        typedef logic [`IDCTL_CBITS-1:0] cbits_t;

        // one JTAG shift word, LSB goes out first
        typedef logic [`IDCTL_JBITS-1:0] jbits_t;

        // bit position inside a serial word
        typedef logic [2:0] bit_idx_t;

        // five steps of one serial bit
        // idle doubles as the settle step before data moves
        typedef enum logic [2:0] {
                PH_IDLE,
                PH_DRIVE,
                PH_RISE,
                PH_SAMPLE,
                PH_FALL
        } bit_phase_e;

endpackage

`default_nettype wire

//--- logic/cpld_loader.sv
`timescale 1ns/10ps
`default_nettype none

`include "idctl_settings.svh"

module cpld_loader (
        input  wire                    clk_i,
        input  wire                    rst_i,
        input  wire                    start_i,
        input  wire idctl_pkg::cbits_t bits_i,
        output logic                   busy_o,
        output logic                   cclk_o,
        output logic                   cdat_o
);
        import idctl_pkg::*;

        // word being shifted out
        cbits_t     bits_q;
        bit_phase_e phase;
        bit_idx_t   idx;

        // a start during a load is dropped, so the word stays put
        always_ff @(posedge clk_i) begin
                if (start_i && !busy_o) begin
                        bits_q <= bits_i;
                end
        end

        always_ff @(posedge clk_i) begin
                if (rst_i) begin
                        busy_o <= 1'b0;
                        phase  <= PH_IDLE;
                        idx    <= '0;
                        cclk_o <= 1'b0;
                        cdat_o <= 1'b0;
                end else if (!busy_o) begin
                        phase <= PH_IDLE;
                        idx   <= '0;
                        if (start_i) begin
                                busy_o <= 1'b1;
                        end
                end else begin
                        // idle, drive, rise, sample, fall, then the next bit
                        if (phase == PH_FALL) begin
                                phase <= PH_IDLE;
                        end else begin
                                phase <= bit_phase_e'(phase + 3'd1);
                        end
                        case (phase)
                        PH_DRIVE: cdat_o <= bits_q[idx];
                        PH_RISE:  cclk_o <= 1'b1;
                        PH_FALL: begin
                                cclk_o <= 1'b0;
                                idx    <= idx + 3'd1;
                                // done after the last bit's fall
                                if (idx == bit_idx_t'(`IDCTL_CBITS - 1)) begin
                                        busy_o <= 1'b0;
                                end
                        end
                        default: ;
                        endcase
                end
        end

endmodule

`default_nettype wire

//--- logic/jtag_port.sv
`timescale 1ns/10ps
`default_nettype none

`include "idctl_settings.svh"

module jtag_port (
        input  wire                   clk_i,
        input  wire                   rst_i,
        input  wire                   jtag_en_i,
        input  wire                   wr_i,
        input  wire idctl_pkg::word_t wdata_i,
        output idctl_pkg::word_t      rdata_o,
        input  wire                   cclk_i,
        input  wire                   cdat_i,
        input  wire                   sclk_i,
        input  wire                   tdo_i,
        output logic                  tck_o,
        output logic                  tms_o,
        output logic                  tdi_o
);
        import idctl_pkg::*;

        jbits_t     tdi_q;
        jbits_t     tms_q;
        jbits_t     tdo_q;
        // bits to shift, minus one
        bit_idx_t   cnt_q;
        logic       rev_q;
        logic       start_q;
        logic       running;
        bit_phase_e phase;
        bit_idx_t   idx;
        // TDO level taken at the sample step
        logic       tdo_s;

        // MSB-first byte into LSB-first shift order
        function automatic jbits_t reverse_bits(input jbits_t d);
                jbits_t r;
                for (int i = 0; i < `IDCTL_JBITS; i++) begin
                        r[i] = d[`IDCTL_JBITS-1-i];
                end
                return r;
        endfunction

        ////////////////////////////////////////////////////////////
        // host fields
        ////////////////////////////////////////////////////////////

        // fields update on every write, even mid shift
        always_ff @(posedge clk_i) begin
                if (rst_i) begin
                        tdi_q   <= '0;
                        tms_q   <= '0;
                        cnt_q   <= '0;
                        rev_q   <= 1'b0;
                        start_q <= 1'b0;
                end else if (wr_i) begin
                        tdi_q   <= wdata_i[29] ? reverse_bits(wdata_i[0 +: `IDCTL_JBITS])
                                               : wdata_i[0 +: `IDCTL_JBITS];
                        tms_q   <= wdata_i[`IDCTL_JBITS +: `IDCTL_JBITS];
                        cnt_q   <= wdata_i[26:24];
                        rev_q   <= wdata_i[29];
                        start_q <= wdata_i[30];
                end
        end

        assign rdata_o = {running, start_q, rev_q, 2'b00, cnt_q, tdo_q, tms_q, tdi_q};

        ////////////////////////////////////////////////////////////
        // bit sequencer and TDO capture
        ////////////////////////////////////////////////////////////

        always_ff @(posedge clk_i) begin
                if (rst_i) begin
                        running <= 1'b0;
                        phase   <= PH_IDLE;
                        idx     <= '0;
                        tdo_s   <= 1'b0;
                        tdo_q   <= '0;
                end else if (!running) begin
                        phase <= PH_IDLE;
                        idx   <= '0;
                        // a start bit only launches an idle shifter
                        if (wr_i && wdata_i[30]) begin
                                running <= 1'b1;
                        end
                end else begin
                        case (phase)
                        PH_SAMPLE: tdo_s <= tdo_i;
                        PH_FALL:   tdo_q[idx] <= tdo_s;
                        default: ;
                        endcase
                        if (phase == PH_FALL) begin
                                phase <= PH_IDLE;
                                idx   <= idx + 3'd1;
                                if (idx == cnt_q) begin
                                        running <= 1'b0;
                                end
                        end else begin
                                phase <= bit_phase_e'(phase + 3'd1);
                        end
                end
        end

        ////////////////////////////////////////////////////////////
        // pin registers
        ////////////////////////////////////////////////////////////

        always_ff @(posedge clk_i) begin
                if (rst_i) begin
                        tck_o <= 1'b0;
                        tms_o <= 1'b0;
                        tdi_o <= 1'b0;
                end else if (!jtag_en_i) begin
                        // loader owns the pins, TMS carries cclk and TDI cdat
                        tdi_o <= cdat_i;
                        tms_o <= cclk_i;
                        tck_o <= sclk_i;
                end else if (running) begin
                        case (phase)
                        PH_DRIVE: begin
                                tdi_o <= tdi_q[idx];
                                tms_o <= tms_q[idx];
                        end
                        PH_RISE: tck_o <= 1'b1;
                        PH_FALL: tck_o <= 1'b0;
                        default: ;
                        endcase
                end
        end

endmodule

`default_nettype wire

//--- logic/idctl_regs.sv
`timescale 1ns/10ps
`default_nettype none

`include "idctl_settings.svh"

module idctl_regs (
        input  wire                       clk_i,
        input  wire                       rst_i,
        input  wire                       req_i,
        input  wire                       we_i,
        input  wire idctl_pkg::reg_addr_t addr_i,
        input  wire idctl_pkg::word_t     wdata_i,
        output logic                      ack_o,
        output idctl_pkg::word_t          rdata_o,
        input  wire                       internal_led_i,
        output logic                      led_o,
        output logic                      reboot_o,
        output idctl_pkg::word_t          boot_addr_o,
        output logic [1:0]                cpld_start_o,
        output idctl_pkg::cbits_t         cpld_bits0_o,
        output idctl_pkg::cbits_t         cpld_bits1_o,
        input  wire [1:0]                 cpld_busy_i,
        output logic                      jtag_en_o,
        output logic [1:0]                jtag_wr_o,
        output idctl_pkg::word_t          jtag_wdata_o,
        input  wire idctl_pkg::word_t     jtag0_rdata_i,
        input  wire idctl_pkg::word_t     jtag1_rdata_i
);
        import idctl_pkg::*;

        // first cycle of a request, ack still low
        logic       access;
        logic       wr;
        // key word seen on the last acked write
        logic       key_ok;
        logic       boot_wr;
        logic       boot_hit;
        logic       cpld_hit;
        logic [1:0] cpld_go;
        logic       led_ovr;
        logic       led_val;

        ////////////////////////////////////////////////////////////
        // four-phase handshake
        ////////////////////////////////////////////////////////////

        // ack follows req one edge later, in both directions
        // so a held req stays one access
        assign access = req_i && !ack_o;
        assign wr     = access && we_i;

        always_ff @(posedge clk_i) begin
                if (rst_i) begin
                        ack_o <= 1'b0;
                end else begin
                        ack_o <= req_i;
                end
        end

        ////////////////////////////////////////////////////////////
        // key lock and reboot
        ////////////////////////////////////////////////////////////

        // version write counts only right after the key write
        assign boot_wr = wr && key_ok && (addr_i == `IDCTL_REG_VERSION);

        always_ff @(posedge clk_i) begin
                if (rst_i) begin
                        key_ok   <= 1'b0;
                        boot_hit <= 1'b0;
                        reboot_o <= 1'b0;
                end else begin
                        // any other write drops the lock again
                        if (wr) begin
                                key_ok <= (addr_i == `IDCTL_REG_ID) && (wdata_i == `IDCTL_KEY);
                        end
                        boot_hit <= boot_wr;
                        reboot_o <= boot_hit;
                end
        end

        always_ff @(posedge clk_i) begin
                if (boot_wr) begin
                        boot_addr_o <= wdata_i;
                end
        end

        ////////////////////////////////////////////////////////////
        // control registers
        ////////////////////////////////////////////////////////////

        // loader starts are locked out while the pins belong to JTAG
        assign cpld_hit = wr && (addr_i == `IDCTL_REG_CPLD) && !jtag_en_o;
        assign cpld_go  = {cpld_hit && wdata_i[24], cpld_hit && wdata_i[8]};

        always_ff @(posedge clk_i) begin
                if (rst_i) begin
                        cpld_start_o <= 2'b00;
                        jtag_en_o    <= 1'b0;
                        led_ovr      <= 1'b0;
                        led_val      <= 1'b0;
                end else begin
                        cpld_start_o <= cpld_go;
                        if (wr && (addr_i == `IDCTL_REG_MODE)) begin
                                jtag_en_o <= wdata_i[31];
                        end
                        if (wr && (addr_i == `IDCTL_REG_LED)) begin
                                led_ovr <= wdata_i[16];
                                led_val <= wdata_i[0];
                        end
                end
        end

        // data byte per side, taken with its start bit
        always_ff @(posedge clk_i) begin
                if (cpld_go[0]) begin
                        cpld_bits0_o <= wdata_i[0 +: `IDCTL_CBITS];
                end
                if (cpld_go[1]) begin
                        cpld_bits1_o <= wdata_i[16 +: `IDCTL_CBITS];
                end
        end

        // led follows the internal source unless overridden
        assign led_o = led_ovr ? led_val : internal_led_i;

        // JTAG sides decode their own fields from the raw word
        assign jtag_wr_o    = {wr && (addr_i == `IDCTL_REG_JTAG1),
                               wr && (addr_i == `IDCTL_REG_JTAG0)};
        assign jtag_wdata_o = wdata_i;

        ////////////////////////////////////////////////////////////
        // read-back
        ////////////////////////////////////////////////////////////

        always_comb begin
                case (addr_i)
                `IDCTL_REG_ID:      rdata_o = `IDCTL_DEVICE_ID;
                `IDCTL_REG_VERSION: rdata_o = `IDCTL_VERSION;
                // busy flags sit in the top bit of each half
                `IDCTL_REG_CPLD:    rdata_o = {cpld_busy_i[1], 7'd0, cpld_bits1_o,
                                               cpld_busy_i[0], 7'd0, cpld_bits0_o};
                `IDCTL_REG_MODE:    rdata_o = {jtag_en_o, 31'd0};
                `IDCTL_REG_LED:     rdata_o = {15'd0, led_ovr, 15'd0, led_o};
                `IDCTL_REG_JTAG0:   rdata_o = jtag0_rdata_i;
                `IDCTL_REG_JTAG1:   rdata_o = jtag1_rdata_i;
                default:            rdata_o = '0;
                endcase
        end

endmodule

`default_nettype wire

//--- logic/idctl_top.sv
`timescale 1ns/10ps
`default_nettype none

module idctl_top (
        input  wire                       clk_i,
        input  wire                       rst_i,
        input  wire                       req_i,
        input  wire                       we_i,
        input  wire idctl_pkg::reg_addr_t addr_i,
        input  wire idctl_pkg::word_t     wdata_i,
        output wire                       ack_o,
        output wire idctl_pkg::word_t     rdata_o,
        input  wire                       internal_led_i,
        output wire                       led_o,
        output wire                       reboot_o,
        output wire idctl_pkg::word_t     boot_addr_o,
        input  wire [1:0]                 sclk_i,
        input  wire [1:0]                 tdo_i,
        output wire [1:0]                 tck_o,
        output wire [1:0]                 tms_o,
        output wire [1:0]                 tdi_o
);
        import idctl_pkg::*;

        // loader side, index is the board side
        wire [1:0]   cpld_start;
        wire cbits_t cpld_bits0;
        wire cbits_t cpld_bits1;
        wire [1:0]   cpld_busy;
        wire [1:0]   cclk;
        wire [1:0]   cdat;
        // JTAG side
        wire         jtag_en;
        wire [1:0]   jtag_wr;
        wire word_t  jtag_wdata;
        wire word_t  jtag0_rdata;
        wire word_t  jtag1_rdata;

        idctl_regs u_regs (
                .clk_i          (clk_i),
                .rst_i          (rst_i),
                .req_i          (req_i),
                .we_i           (we_i),
                .addr_i         (addr_i),
                .wdata_i        (wdata_i),
                .ack_o          (ack_o),
                .rdata_o        (rdata_o),
                .internal_led_i (internal_led_i),
                .led_o          (led_o),
                .reboot_o       (reboot_o),
                .boot_addr_o    (boot_addr_o),
                .cpld_start_o   (cpld_start),
                .cpld_bits0_o   (cpld_bits0),
                .cpld_bits1_o   (cpld_bits1),
                .cpld_busy_i    (cpld_busy),
                .jtag_en_o      (jtag_en),
                .jtag_wr_o      (jtag_wr),
                .jtag_wdata_o   (jtag_wdata),
                .jtag0_rdata_i  (jtag0_rdata),
                .jtag1_rdata_i  (jtag1_rdata)
        );

        cpld_loader u_cpld0 (
                .clk_i   (clk_i),
                .rst_i   (rst_i),
                .start_i (cpld_start[0]),
                .bits_i  (cpld_bits0),
                .busy_o  (cpld_busy[0]),
                .cclk_o  (cclk[0]),
                .cdat_o  (cdat[0])
        );

        cpld_loader u_cpld1 (
                .clk_i   (clk_i),
                .rst_i   (rst_i),
                .start_i (cpld_start[1]),
                .bits_i  (cpld_bits1),
                .busy_o  (cpld_busy[1]),
                .cclk_o  (cclk[1]),
                .cdat_o  (cdat[1])
        );

        // on the board TMS is also the CPLD clock and TDI the CPLD data
        jtag_port u_jtag0 (
                .clk_i     (clk_i),
                .rst_i     (rst_i),
                .jtag_en_i (jtag_en),
                .wr_i      (jtag_wr[0]),
                .wdata_i   (jtag_wdata),
                .rdata_o   (jtag0_rdata),
                .cclk_i    (cclk[0]),
                .cdat_i    (cdat[0]),
                .sclk_i    (sclk_i[0]),
                .tdo_i     (tdo_i[0]),
                .tck_o     (tck_o[0]),
                .tms_o     (tms_o[0]),
                .tdi_o     (tdi_o[0])
        );

        jtag_port u_jtag1 (
                .clk_i     (clk_i),
                .rst_i     (rst_i),
                .jtag_en_i (jtag_en),
                .wr_i      (jtag_wr[1]),
                .wdata_i   (jtag_wdata),
                .rdata_o   (jtag1_rdata),
                .cclk_i    (cclk[1]),
                .cdat_i    (cdat[1]),
                .sclk_i    (sclk_i[1]),
                .tdo_i     (tdo_i[1]),
                .tck_o     (tck_o[1]),
                .tms_o     (tms_o[1]),
                .tdi_o     (tdi_o[1])
        );

endmodule

`default_nettype wire

//--- bench/idctl_tb.sv
`timescale 1ns/10ps
`default_nettype none

`include "idctl_settings.svh"

module idctl_tb;
        import idctl_pkg::*;

        // cycles allowed for one ack edge, and reads allowed for one poll
        localparam int ACK_WAIT = 20;
        localparam int POLL_MAX = 100;

        logic       clk_i;
        logic       rst_i;
        logic       req;
        logic       we;
        reg_addr_t  addr;
        word_t      wdata;
        wire        ack;
        wire word_t rdata;
        logic       internal_led;
        wire        led;
        wire        reboot;
        wire word_t boot_addr;
        logic [1:0] sclk;
        wire [1:0]  tdo;
        wire [1:0]  tck;
        wire [1:0]  tms;
        wire [1:0]  tdi;

        integer     seed;
        int         reboot_cnt = 0;
        word_t      reboot_addr;
        // CPLD data bits seen at each rising CPLD clock, per side
        bit         cap0[$];
        bit         cap1[$];

        idctl_top UUT (
                .clk_i          (clk_i),
                .rst_i          (rst_i),
                .req_i          (req),
                .we_i           (we),
                .addr_i         (addr),
                .wdata_i        (wdata),
                .ack_o          (ack),
                .rdata_o        (rdata),
                .internal_led_i (internal_led),
                .led_o          (led),
                .reboot_o       (reboot),
                .boot_addr_o    (boot_addr),
                .sclk_i         (sclk),
                .tdo_i          (tdo),
                .tck_o          (tck),
                .tms_o          (tms),
                .tdi_o          (tdi)
        );

        initial clk_i = 1'b0;
        always #50 clk_i = ~clk_i;

        ////////////////////////////////////////////////////////////
        // pin models
        ////////////////////////////////////////////////////////////

        // TDO wired straight back to TDI on each side
        assign tdo = tdi;

        // TMS is the CPLD clock, TDI the CPLD data
        always @(posedge tms[0]) cap0.push_back(tdi[0]);
        always @(posedge tms[1]) cap1.push_back(tdi[1]);

        // count reboot pulses mid cycle
        always @(negedge clk_i) begin
                if (reboot) begin
                        reboot_cnt++;
                        reboot_addr = boot_addr;
                end
        end

        ////////////////////////////////////////////////////////////
        // helpers
        ////////////////////////////////////////////////////////////

        // next rising edge plus drive offset
        task automatic tick();
                @(posedge clk_i);
                #10;
        endtask

        task automatic end_with_failure();
                $display("test failed");
                $fatal(1);
        endtask

        task automatic check_eq(input word_t got, input word_t exp, input string what);
                if (got !== exp) begin
                        $display("[ERROR] %0t: %s, got %h expected %h", $time, what, got, exp);
                        end_with_failure();
                end
        endtask

        task automatic wait_ack(input logic level, input string what);
                int n;
                n = 0;
                while (ack !== level) begin
                        if (n == ACK_WAIT) begin
                                $display("timeout: ack did not %s", what);
                                end_with_failure();
                        end
                        tick();
                        n++;
                end
        endtask

        task automatic host_write(input reg_addr_t a, input word_t d);
                req   = 1'b1;
                we    = 1'b1;
                addr  = a;
                wdata = d;
                wait_ack(1'b1, "rise on a write");
                req = 1'b0;
                we  = 1'b0;
                wait_ack(1'b0, "fall after a write");
        endtask

        task automatic host_read(input reg_addr_t a, output word_t q);
                req  = 1'b1;
                we   = 1'b0;
                addr = a;
                wait_ack(1'b1, "rise on a read");
                // read data is valid while ack is high
                q   = rdata;
                req = 1'b0;
                wait_ack(1'b0, "fall after a read");
        endtask

        // read until a status bit clears
        task automatic poll_clear(input reg_addr_t a, input int pos, input string what,
                                  output word_t q);
                int n;
                n = 0;
                host_read(a, q);
                while (q[pos]) begin
                        if (n == POLL_MAX) begin
                                $display("timeout: %s never cleared", what);
                                end_with_failure();
                        end
                        host_read(a, q);
                        n++;
                end
        endtask

        function automatic logic [7:0] flip_byte(input logic [7:0] b);
                logic [7:0] r;
                for (int i = 0; i < 8; i++) begin
                        r[i] = b[7-i];
                end
                return r;
        endfunction

        ////////////////////////////////////////////////////////////
        // directed tests
        ////////////////////////////////////////////////////////////

        task automatic test_ids_and_led();
                word_t q;
                host_read(`IDCTL_REG_ID, q);
                check_eq(q, `IDCTL_DEVICE_ID, "device ID word");
                host_read(`IDCTL_REG_VERSION, q);
                check_eq(q, `IDCTL_VERSION, "version word");
                host_read(`IDCTL_REG_LED, q);
                check_eq(q[16], 1'b0, "LED override after reset");
                check_eq(q[0], internal_led, "LED value after reset");
                // no override, so led tracks the internal source
                for (int i = 0; i < 4; i++) begin
                        internal_led = ~internal_led;
                        tick();
                        check_eq(led, internal_led, "led following internal LED");
                end
        endtask

        task automatic test_sclk_follow(input int side);
                // pins registered once, so one edge of latency
                sclk[side] = 1'b1;
                tick();
                check_eq(tck[side], 1'b1, "TCK following sclk high");
                sclk[side] = 1'b0;
                tick();
                check_eq(tck[side], 1'b0, "TCK following sclk low");
        endtask

        task automatic test_cpld_load(input int side);
                word_t      q;
                word_t      w;
                logic [7:0] b;
                logic [7:0] built;
                bit         got_bits[$];
                b = $random(seed);
                cap0.delete();
                cap1.delete();
                w = (side == 0) ? {23'd0, 1'b1, b} : {7'd0, 1'b1, b, 16'd0};
                host_write(`IDCTL_REG_CPLD, w);
                host_read(`IDCTL_REG_CPLD, q);
                check_eq(q[side*16+15], 1'b1, "CPLD busy after start");
                poll_clear(`IDCTL_REG_CPLD, side * 16 + 15, "CPLD busy", q);
                check_eq(q[side*16 +: 8], b, "CPLD data read-back");
                if (side == 0) begin
                        got_bits = cap0;
                end else begin
                        got_bits = cap1;
                end
                check_eq(got_bits.size(), 8, "CPLD clock pulses on the pins");
                // first bit on the wire is the LSB
                for (int i = 0; i < 8; i++) begin
                        built[i] = got_bits[i];
                end
                check_eq(built, b, "CPLD byte rebuilt from the pins");
        endtask

        task automatic test_jtag_shift(input int side, input bit rev);
                word_t      q;
                word_t      w;
                reg_addr_t  a;
                logic [7:0] tdi_v;
                logic [7:0] tms_v;
                logic [7:0] exp;
                tdi_v = $random(seed);
                tms_v = $random(seed);
                a     = (side == 0) ? `IDCTL_REG_JTAG0 : `IDCTL_REG_JTAG1;
                // start, reverse flag, count 7 means eight bits
                w = {1'b0, 1'b1, rev, 2'b00, 3'd7, 8'h00, tms_v, tdi_v};
                host_write(a, w);
                // loader starts must be locked out in JTAG mode
                host_write(`IDCTL_REG_CPLD, {7'd0, 1'b1, 8'ha5, 7'd0, 1'b1, 8'h5a});
                host_read(`IDCTL_REG_CPLD, q);
                check_eq(q[15], 1'b0, "CPLD side 0 busy in JTAG mode");
                check_eq(q[31], 1'b0, "CPLD side 1 busy in JTAG mode");
                poll_clear(a, 31, "JTAG running", q);
                exp = rev ? flip_byte(tdi_v) : tdi_v;
                check_eq(q[7:0], exp, "JTAG TDI field");
                check_eq(q[15:8], tms_v, "JTAG TMS field");
                check_eq(q[23:16], exp, "JTAG TDO through loopback");
        endtask

        task automatic test_reboot();
                word_t target;
                int    n;
                target = $random(seed);
                host_write(`IDCTL_REG_ID, `IDCTL_KEY);
                host_write(`IDCTL_REG_VERSION, target);
                n = 0;
                while (reboot_cnt == 0) begin
                        if (n == 10) begin
                                $display("no reboot pulse after key and version writes");
                                end_with_failure();
                        end
                        tick();
                        n++;
                end
                // a second count here would mean a wide pulse
                repeat (3) tick();
                check_eq(reboot_cnt, 1, "reboot pulse count");
                check_eq(reboot_addr, target, "boot address");
                // any write between key and version breaks the lock
                host_write(`IDCTL_REG_ID, `IDCTL_KEY);
                host_write(`IDCTL_REG_MODE, 32'd0);
                host_write(`IDCTL_REG_VERSION, ~target);
                repeat (5) tick();
                check_eq(reboot_cnt, 1, "reboot pulse without a fresh key");
        endtask

        task automatic test_led_override();
                word_t q;
                logic  v;
                v = $random(seed);
                host_write(`IDCTL_REG_LED, {15'd0, 1'b1, 15'd0, v});
                for (int i = 0; i < 3; i++) begin
                        internal_led = ~internal_led;
                        tick();
                        check_eq(led, v, "led under override");
                end
                host_read(`IDCTL_REG_LED, q);
                check_eq(q[16], 1'b1, "LED override read-back");
                check_eq(q[0], v, "LED value read-back");
                host_write(`IDCTL_REG_LED, 32'd0);
                for (int i = 0; i < 3; i++) begin
                        internal_led = ~internal_led;
                        tick();
                        check_eq(led, internal_led, "led after override cleared");
                end
        endtask

        ////////////////////////////////////////////////////////////
        // main sequence
        ////////////////////////////////////////////////////////////

        initial begin
                seed         = 82947;
                rst_i        = 1'b1;
                req          = 1'b0;
                we           = 1'b0;
                addr         = '0;
                wdata        = '0;
                internal_led = 1'b0;
                sclk         = 2'b00;
                repeat (5) @(posedge clk_i);
                #10;
                rst_i = 1'b0;
                tick();

                test_ids_and_led();
                test_sclk_follow(0);
                test_sclk_follow(1);
                test_cpld_load(0);
                test_cpld_load(1);

                // hand the pins to the JTAG shifters
                host_write(`IDCTL_REG_MODE, 32'h8000_0000);
                test_jtag_shift(0, 1'b0);
                test_jtag_shift(0, 1'b1);
                test_jtag_shift(1, 1'b0);
                test_jtag_shift(1, 1'b1);
                host_write(`IDCTL_REG_MODE, 32'd0);

                test_reboot();
                test_led_override();

                $display("test passed");
                $finish;
        end

endmodule

`default_nettype wire

//--- idctl_top.f
+incdir+logic
logic/idctl_pkg.sv
logic/cpld_loader.sv
logic/jtag_port.sv
logic/idctl_regs.sv
logic/idctl_top.sv
bench/idctl_tb.sv

//--- Bender.yml
package:
  name: idctl

sources:
  - include_dirs:
      - logic
    files:
      - logic/idctl_pkg.sv
      - logic/cpld_loader.sv
      - logic/jtag_port.sv
      - logic/idctl_regs.sv
      - logic/idctl_top.sv
  - target: simulation
    include_dirs:
      - logic
    files:
      - bench/idctl_tb.sv
